/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= boothMultiplierTb
FILELIST  ?= verilog.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* dv/boothMultiplierTb.sv */
`timescale 1ns/10ps

module boothMultiplierTb;

    localparam int WIDTH        = 16;
    localparam int RANDOM_CASES = 40;

    logic               clk;
    logic               reset;
    logic               start;
    logic [WIDTH-1:0]   multiplicand;
    logic [WIDTH-1:0]   multiplier;
    logic               ready;
    logic [2*WIDTH-1:0] product;

    logic [WIDTH-1:0]   caseA[$];     // directed multiplicands
    logic [WIDTH-1:0]   caseB[$];     // directed multipliers
    logic [2*WIDTH-1:0] caseP[$];     // directed products
    logic [31:0]        lfsrState;
    int                 valueErrors  = 0;
    int                 timingErrors = 0;
    int                 setupErrors  = 0;
    int                 cycleCount   = 0;
    int                 cycleLimit   = 100000;   // replaced once the cases are known

    boothMultiplier #(
        .WIDTH (WIDTH)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .ready        (ready),
        .product      (product)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // watchdog
    initial
    begin
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped after %0d cycles without reaching the end of the tests",
                 cycleCount);
        $display(">>> FAIL");
        $finish;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic feedback;
        feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], feedback};
    endfunction

    function automatic logic [WIDTH-1:0] randomOperand();
        logic [WIDTH-1:0] value;
        value = '0;
        for (int k = 0; k < WIDTH; k++)
        begin
            lfsrState = lfsrNext(lfsrState);       // one step per bit
            value     = {value[WIDTH-2:0], lfsrState[0]};
        end
        return value;
    endfunction

    // two's-complement product of the two operands
    function automatic logic [2*WIDTH-1:0] signedProduct(input logic [WIDTH-1:0] a,
                                                         input logic [WIDTH-1:0] b);
        logic signed [2*WIDTH-1:0] wideA;
        logic signed [2*WIDTH-1:0] wideB;
        wideA = {{WIDTH{a[WIDTH-1]}}, a};
        wideB = {{WIDTH{b[WIDTH-1]}}, b};
        return wideA * wideB;
    endfunction

    task automatic loadCases();
        int                 fd;
        int                 got;
        int                 n;
        string              line;
        logic [WIDTH-1:0]   a;
        logic [WIDTH-1:0]   b;
        logic [2*WIDTH-1:0] p;
        fd = $fopen("dv/multiplyCases.txt", "r");
        if (fd == 0)
        begin
            setupErrors++;
            $display("could not open dv/multiplyCases.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "/")   // skip comment lines
                begin
                    got = $sscanf(line, "%h %h %h", a, b, p);
                    if (got == 3)
                    begin
                        caseA.push_back(a);
                        caseB.push_back(b);
                        caseP.push_back(p);
                    end
                end
            end
            $fclose(fd);
        end
        if (caseA.size() == 0)
        begin
            setupErrors++;
            $display("no directed cases were read from the cases file");
        end
    endtask

    // runs one multiplication and then the requested idle cycles
    task automatic runMultiply(input logic [WIDTH-1:0]   a,
                               input logic [WIDTH-1:0]   b,
                               input logic [2*WIDTH-1:0] expected,
                               input int                 holdCycles,
                               input bit                 midStart);
        int cycles;
        bit readySeen;
        @(posedge clk);
        #1;
        start        = 1'b1;
        multiplicand = a;
        multiplier   = b;
        @(negedge clk);
        assert (ready === 1'b0)
        else
        begin
            timingErrors++;
            $display("ready was still high in the cycle that starts %h * %h", a, b);
        end
        @(posedge clk);   // edge 0
        #1;
        start     = 1'b0;
        cycles    = 0;
        readySeen = 1'b0;
        while (!readySeen && cycles < WIDTH + 8)
        begin
            @(negedge clk);
            cycles++;
            readySeen = (ready === 1'b1);
            if (!readySeen)
            begin
                @(posedge clk);
                #1;
                start = 1'b0;
                if (midStart && cycles == WIDTH / 2)
                begin
                    start        = 1'b1;   // should be ignored while busy
                    multiplicand = 16'h7fff;
                    multiplier   = 16'h8001;
                end
            end
        end
        assert (readySeen)
        else
        begin
            timingErrors++;
            $display("ready did not rise within %0d cycles for %h * %h", cycles, a, b);
        end
        if (readySeen)
        begin
            assert (cycles == WIDTH + 1)
            else
            begin
                timingErrors++;
                $display("ready came %0d cycles after start instead of %0d", cycles, WIDTH + 1);
            end
            assert (product === expected)
            else
            begin
                valueErrors++;
                $display("Error: product = %h, expected %h (%h * %h)", product, expected, a, b);
            end
        end
        repeat (holdCycles)
        begin
            @(posedge clk);
            #1;
            multiplicand = ~a;   // new operands without a start
            multiplier   = ~b;
            @(negedge clk);
            assert (ready === 1'b0)
            else
            begin
                timingErrors++;
                $display("ready stayed high for more than one cycle after %h * %h", a, b);
            end
            assert (product === expected)
            else
            begin
                valueErrors++;
                $display("Error: held product = %h, expected %h", product, expected);
            end
        end
    endtask

    initial
    begin
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        reset        = 1'b0;
        start        = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        lfsrState    = 32'he219_af99;
        loadCases();
        cycleLimit = (caseA.size() + RANDOM_CASES + 1) * (WIDTH + 4) + 200;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b1;
        @(negedge clk);
        assert (ready === 1'b0)
        else
        begin
            valueErrors++;
            $display("Error: ready = %h after reset, expected 0", ready);
        end
        assert (product === '0)
        else
        begin
            valueErrors++;
            $display("Error: product = %h after reset, expected 00000000", product);
        end

        for (int i = 0; i < caseA.size(); i++)
        begin
            runMultiply(caseA[i], caseB[i], caseP[i], (i == 0) ? 6 : 2, 1'b0);
        end

        runMultiply(16'h4321, 16'h8765, signedProduct(16'h4321, 16'h8765), 2, 1'b1);

        for (int i = 0; i < RANDOM_CASES; i++)
        begin
            a = randomOperand();
            b = randomOperand();
            // even cases run back to back
            runMultiply(a, b, signedProduct(a, b), (i % 2 == 0) ? 0 : 2, 1'b0);
        end

        $display("errors: %0d value, %0d timing, %0d setup",
                 valueErrors, timingErrors, setupErrors);
        if (valueErrors + timingErrors + setupErrors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* dv/multiplyCases.txt */
// multiplicand multiplier expected_product, all hex, two's complement
// 16-bit operands, 32-bit product
0000 0000 00000000
0000 1234 00000000
0001 0001 00000001
0001 ffff ffffffff
ffff ffff 00000001
8000 ffff 00008000
8000 8000 40000000
8000 0001 ffff8000
7fff 7fff 3fff0001
7fff 8000 c0008000
8000 7fff c0008000
0003 fffb fffffff1
fff9 0006 ffffffd6
5555 5555 1c718e39
aaaa aaaa 1c7238e4
5555 aaaa e38e1c72
1234 5678 06260060
edcc 5678 f9d9ffa0
00ff ff01 ffff01ff
0f0f f0f0 ff1d2e10

/* hdl/accumulatorUnit.sv */
`timescale 1ns/10ps

module accumulatorUnit #(
    parameter int WIDTH = boothDataPkg::DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] multiplicand,
    boothCtrlIf.acc          bus,
    output logic [WIDTH-1:0] accumulator,
    output logic             shiftBit
);
    import boothCtrlPkg::*;

    logic [WIDTH-1:0] mReg;       // M
    logic [WIDTH-1:0] acc;        // A
    logic [WIDTH:0]   accWide;
    logic [WIDTH:0]   mWide;
    logic [WIDTH:0]   stepSum;

    // One guard bit keeps A - M exact when M is the most negative value.
    // The shifted result always fits back into WIDTH bits.
    assign accWide = {acc[WIDTH-1], acc};
    assign mWide   = {mReg[WIDTH-1], mReg};

    always_comb
    begin
        case (bus.selectAccumulator)
            ACC_ADD:      stepSum = accWide + mWide;
            ACC_SUB:      stepSum = accWide - mWide;
            ACC_HOLD:     stepSum = accWide;
            ACC_HOLD_ALT: stepSum = accWide;
            default:      stepSum = accWide;
        endcase
    end

    assign shiftBit = stepSum[0];   // enters the multiplier MSB

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            mReg <= '0;
            acc  <= '0;
        end
        else if (bus.enable)
        begin
            if (!bus.selectMultiplier)
            begin
                mReg <= multiplicand;
                acc  <= '0;
            end
            else
            begin
                acc <= stepSum[WIDTH:1];   // arithmetic shift right
            end
        end
    end

    assign accumulator = acc;

    // recoding from the controller must be resolved on every step
    assert property (@(posedge clk) disable iff (!reset)
        (bus.enable && bus.selectMultiplier) |-> !$isunknown(bus.selectAccumulator));

endmodule

/* hdl/boothController.sv */
`timescale 1ns/10ps

module boothController (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    output logic       ready,
    boothCtrlIf.ctrl   bus
);
    import boothCtrlPkg::*;

    ctrlState_t currentState;
    ctrlState_t nextState;
    accSelect_t pairSelect;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            currentState <= IDLE;
        end
        else
        begin
            currentState <= nextState;
        end
    end

    // next state
    always_comb
    begin
        nextState = currentState;
        case (currentState)
            IDLE:
            begin
                if (start)
                begin
                    nextState = PROCESS;   // operands load on this edge
                end
            end
            PROCESS:
            begin
                if (bus.count16)
                begin
                    nextState = IDLE;
                end
            end
            default:
            begin
                nextState = IDLE;
            end
        endcase
    end

    // Booth recoding of Q0, Q-1
    always_comb
    begin
        case (bus.operation)
            2'b01:   pairSelect = ACC_ADD;        // end of a run of ones
            2'b10:   pairSelect = ACC_SUB;        // start of a run of ones
            2'b11:   pairSelect = ACC_HOLD_ALT;
            default: pairSelect = ACC_HOLD;
        endcase
    end

    // outputs, start and count16 act within the cycle
    always_comb
    begin
        ready                 = 1'b0;
        bus.enable            = 1'b0;
        bus.selectMultiplier  = 1'b0;
        bus.selectAccumulator = ACC_HOLD;
        case (currentState)
            IDLE:
            begin
                bus.enable = start;            // load strobe
            end
            PROCESS:
            begin
                bus.selectMultiplier  = 1'b1;
                bus.selectAccumulator = pairSelect;
                bus.enable            = !bus.count16;
                ready                 = bus.count16;   // product complete
            end
            default:
            begin
                ready = 1'b0;
            end
        endcase
    end

    // a finished product never coincides with a datapath update
    assert property (@(posedge clk) disable iff (!reset) !(ready && bus.enable));

    // ready is a single-cycle strobe
    assert property (@(posedge clk) disable iff (!reset) ready |=> !ready);

endmodule

/* hdl/boothCtrlIf.sv */
`timescale 1ns/10ps

interface boothCtrlIf #(
    parameter int WIDTH = boothDataPkg::DEFAULT_WIDTH
);
    import boothCtrlPkg::*;

    logic       enable;              // load or step this cycle
    logic       selectMultiplier;    // 0 load, 1 Booth step
    accSelect_t selectAccumulator;   // add, subtract or hold
    boothPair_t operation;           // Q0 and Q-1
    logic       count16;             // all steps done

    // a Booth pair needs at least two operand bits
    if (WIDTH < 2)
    begin : gWidthCheck
        $error("boothCtrlIf: WIDTH must be at least 2");
    end

    modport ctrl (
        output enable, selectMultiplier, selectAccumulator,
        input  operation, count16
    );

    modport acc (
        input enable, selectMultiplier, selectAccumulator
    );

    modport step (
        input  enable, selectMultiplier,
        output operation, count16
    );

endinterface

/* hdl/boothCtrlPkg.sv */
package boothCtrlPkg;

    // controller states
    typedef enum logic
    {
        IDLE    = 1'b0,   // waiting for start
        PROCESS = 1'b1    // running Booth steps
    } ctrlState_t;

    // accumulator action for one Booth step
    typedef enum logic [1:0]
    {
        ACC_HOLD     = 2'b00,   // A
        ACC_ADD      = 2'b01,   // A + M
        ACC_SUB      = 2'b10,   // A - M
        ACC_HOLD_ALT = 2'b11    // A, pair 11
    } accSelect_t;

    // Booth pair, Q0 in bit 1 and Q-1 in bit 0
    typedef logic [1:0] boothPair_t;

endpackage

/* hdl/boothDataPkg.sv */
package boothDataPkg;

    // operand width when the top level is not overridden
    localparam int DEFAULT_WIDTH = 16;

    // Counter width for a run of width steps.
    // One extra bit so that the count can reach width itself.
    function automatic int stepBits(input int width);
        return $clog2(width) + 1;
    endfunction

endpackage

/* hdl/boothMultiplier.sv */
`timescale 1ns/10ps

module boothMultiplier #(
    parameter int WIDTH = boothDataPkg::DEFAULT_WIDTH
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic [WIDTH-1:0]   multiplicand,
    input  logic [WIDTH-1:0]   multiplier,
    output logic               ready,
    output logic [2*WIDTH-1:0] product
);

    logic [WIDTH-1:0] accumulator;
    logic [WIDTH-1:0] multiplierBits;
    logic             shiftBit;

    boothCtrlIf #(
        .WIDTH (WIDTH)
    ) bus ();

    boothController uController (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .ready (ready),
        .bus   (bus.ctrl)
    );

    stepCounter #(
        .WIDTH (WIDTH)
    ) uStepCounter (
        .clk   (clk),
        .reset (reset),
        .bus   (bus.step)
    );

    accumulatorUnit #(
        .WIDTH (WIDTH)
    ) uAccumulator (
        .clk          (clk),
        .reset        (reset),
        .multiplicand (multiplicand),
        .bus          (bus.acc),
        .accumulator  (accumulator),
        .shiftBit     (shiftBit)
    );

    multiplierRegister #(
        .WIDTH (WIDTH)
    ) uMultiplierReg (
        .clk            (clk),
        .reset          (reset),
        .multiplier     (multiplier),
        .shiftBit       (shiftBit),
        .bus            (bus.step),
        .multiplierBits (multiplierBits)
    );

    assign product = {accumulator, multiplierBits};   // A high, Q low

endmodule

/* hdl/multiplierRegister.sv */
`timescale 1ns/10ps

module multiplierRegister #(
    parameter int WIDTH = boothDataPkg::DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] multiplier,
    input  logic             shiftBit,
    boothCtrlIf.step         bus,
    output logic [WIDTH-1:0] multiplierBits
);

    logic [WIDTH-1:0] q;       // Q, low half of the product at the end
    logic             qPrev;   // Q-1

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            q     <= '0;
            qPrev <= 1'b0;
        end
        else if (bus.enable)
        begin
            if (!bus.selectMultiplier)
            begin
                q     <= multiplier;
                qPrev <= 1'b0;
            end
            else
            begin
                q     <= {shiftBit, q[WIDTH-1:1]};   // bit from A joins at the top
                qPrev <= q[0];
            end
        end
    end

    assign bus.operation = {q[0], qPrev};
    assign multiplierBits = q;

endmodule

/* hdl/stepCounter.sv */
`timescale 1ns/10ps

module stepCounter #(
    parameter int WIDTH = boothDataPkg::DEFAULT_WIDTH
) (
    input logic      clk,
    input logic      reset,
    boothCtrlIf.step bus
);
    import boothDataPkg::*;

    localparam int COUNT_BITS = stepBits(WIDTH);

    logic [COUNT_BITS-1:0] count;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            count <= '0;
        end
        else if (bus.enable)
        begin
            if (!bus.selectMultiplier)
            begin
                count <= '0;               // new operands
            end
            else
            begin
                count <= count + 1'b1;     // one Booth step
            end
        end
    end

    assign bus.count16 = (count == COUNT_BITS'(WIDTH));

    // controller must stop stepping once the last step is flagged
    assert property (@(posedge clk) disable iff (!reset) count <= COUNT_BITS'(WIDTH));

endmodule

/* verilog.f */
hdl/boothCtrlPkg.sv
hdl/boothDataPkg.sv
hdl/boothCtrlIf.sv
hdl/stepCounter.sv
hdl/accumulatorUnit.sv
hdl/multiplierRegister.sv
hdl/boothController.sv
hdl/boothMultiplier.sv
dv/boothMultiplierTb.sv
